/* flist.f */
rtl/wbm_pkg.sv
rtl/word_fifo.sv
rtl/host_rx.sv
rtl/host_tx.sv
rtl/wb_cycle.sv
rtl/wbm_sequencer.sv
rtl/wbm_top.sv
dv/tb_clk_gen.sv
dv/wb_slave_model.sv
dv/tb_top.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module tb_top -f flist.f -Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
echo "pass line not found in the simulation output"
exit 1

/* dv/tb_top.sv */
`timescale 1ns/1ps
// testbench for the wishbone host master
// sends host commands under credit flow control and checks every response word

module tb_top;

   // six tests of at most 2*TIMEOUT_CYCLES each, with wide margin for slow credits
   localparam int CYCLE_LIMIT = 5000;

   logic             wb_clk;
   logic             wb_rst;
   logic             in_valid_i   = 1'b0;
   wbm_pkg::word_t   in_word_i    = '0;
   logic             in_credit_o;
   logic             out_valid_o;
   wbm_pkg::word_t   out_word_o;
   logic             out_credit_i = 1'b0;
   wbm_pkg::wb_m2s_t bus_m2s;
   wbm_pkg::wb_s2m_t bus_s2m;

   int             seed          = 32'h5c3b;
   int             errors        = 0;
   int             tests_failed  = 0;
   int             cycles        = 0;
   int             in_credits    = wbm_pkg::FIFO_DEPTH;   // credits the host may still spend
   int             in_flight     = 0;                     // words sent minus credits returned
   int             held          = 0;                     // response words not yet credited back
   int             credit_thresh = 6;                     // credit chance in eighths per clock
   logic           skip_window   = 1'b0;                  // no bus cycle may run while high
   wbm_pkg::word_t tx_words   [$];                        // words waiting for an input credit
   wbm_pkg::word_t rx_words   [$];                        // response words seen at the out port
   wbm_pkg::word_t data_words [$];
   wbm_pkg::word_t exp_words  [$];
   wbm_pkg::word_t shadow     [64];                       // expected slave memory

   tb_clk_gen u_clk (.wb_clk (wb_clk), .wb_rst (wb_rst));

   wbm_top uut (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .in_valid_i (in_valid_i), .in_word_i (in_word_i), .in_credit_o (in_credit_o),
      .out_valid_o (out_valid_o), .out_word_o (out_word_o), .out_credit_i (out_credit_i),
      .wb_o (bus_m2s), .wb_i (bus_s2m)
   );

   wb_slave_model u_slave (.wb_clk (wb_clk), .wb_rst (wb_rst), .m2s_i (bus_m2s), .s2m_o (bus_s2m));

   // ----------------------------------------------------------------------
   // host side of the two credit streams
   always @(posedge wb_clk) begin : host_in
      int             avail;
      wbm_pkg::word_t next_in;
      if (wb_rst) begin
         in_credits <= wbm_pkg::FIFO_DEPTH;
         in_valid_i <= 1'b0;
      end else begin
         avail = in_credits + (in_credit_o ? 1 : 0);   // a returned credit is usable at once
         if (tx_words.size() != 0 && avail > 0) begin
            next_in    = tx_words.pop_front();
            in_valid_i <= 1'b1;
            in_word_i  <= next_in;
            avail      = avail - 1;
         end else begin
            in_valid_i <= 1'b0;
         end
         in_credits <= avail;
      end
   end

   always @(posedge wb_clk) begin
      if (wb_rst) in_flight <= 0;
      else        in_flight <= in_flight + (in_valid_i ? 1 : 0) - (in_credit_o ? 1 : 0);
   end

   always @(posedge wb_clk) begin : host_out
      int roll;
      int kept;
      if (wb_rst) begin
         held         <= 0;
         out_credit_i <= 1'b0;
      end else begin
         if (out_valid_o) rx_words.push_back(out_word_o);
         kept = held + (out_valid_o ? 1 : 0) - (out_credit_i ? 1 : 0);
         roll = $random(seed);
         // the host frees its buffer at random, which throttles the out stream
         out_credit_i <= (kept > 0) && ((roll & 7) < credit_thresh);
         held         <= kept;
      end
   end

   // ----------------------------------------------------------------------
   // protocol checks that run for the whole simulation
   assert property (@(posedge wb_clk) disable iff (wb_rst) held <= wbm_pkg::FIFO_DEPTH)
      else begin
         $display("out stream sent more words than the host had credited");
         errors++;
      end
   // a credit for a word never received would let the host overrun the input queue
   assert property (@(posedge wb_clk) disable iff (wb_rst)
                    in_flight >= 0 && in_flight <= wbm_pkg::FIFO_DEPTH)
      else begin
         $display("input credits do not match the words the host has sent");
         errors++;
      end
   assert property (@(posedge wb_clk) disable iff (wb_rst) skip_window |-> !bus_m2s.cyc)
      else begin
         $display("a bus cycle ran while a timeout was still pending");
         errors++;
      end

   always @(posedge wb_clk) begin
      if (cycles == CYCLE_LIMIT) begin
         $display("timeout, the tests did not finish within %0d cycles", CYCLE_LIMIT);
         $display("CHECKS FAILED");
         $finish;
      end else begin
         cycles <= cycles + 1;
      end
   end

   // ----------------------------------------------------------------------
   function automatic wbm_pkg::word_t make_cmd(wbm_pkg::op_t op, int count, int id,
                                               logic cont, int step);
      wbm_pkg::cmd_t c;
      c.op        = op;
      c.count     = wbm_pkg::count_t'(count);
      c.id        = 8'(id);
      c.cont      = cont;
      c.addr_step = 8'(step);
      return wbm_pkg::word_t'(c);
   endfunction

   function automatic int mem_index(wbm_pkg::word_t addr, int beat, int step);
      return (int'(addr[5:0]) + beat * step) % 64;   // the slave decodes six address bits
   endfunction

   // command, address and mask go first, then whatever sits in data_words
   task automatic send_command(input wbm_pkg::word_t cmd_w, input wbm_pkg::word_t addr,
                               input wbm_pkg::word_t mask);
      tx_words.push_back(cmd_w);
      tx_words.push_back(addr);
      tx_words.push_back(mask);
      foreach (data_words[i]) tx_words.push_back(data_words[i]);
      data_words.delete();
   endtask

   task automatic next_word(output wbm_pkg::word_t w);
      while (rx_words.size() == 0) @(posedge wb_clk);
      w = rx_words.pop_front();
   endtask

   task automatic check_word(input string name, input wbm_pkg::word_t exp,
                             input wbm_pkg::word_t act);
      assert (act === exp)
         else begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            errors++;
         end
   endtask

   // echo, data words, last address and result word, against exp_words
   task automatic check_response(input string name, input wbm_pkg::word_t cmd_w,
                                 input wbm_pkg::word_t addr, input logic check_data,
                                 input wbm_pkg::word_t result);
      wbm_pkg::cmd_t  c;
      wbm_pkg::word_t w;
      wbm_pkg::word_t last_addr;
      int             beats;
      int             i;
      c         = wbm_pkg::cmd_t'(cmd_w);
      beats     = (c.op == wbm_pkg::OP_READ) ? int'(c.count) : 1;
      last_addr = addr + wbm_pkg::word_t'((int'(c.count) - 1) * int'(c.addr_step));
      next_word(w);
      check_word({name, " echo"}, cmd_w, w);
      for (i = 0; i < beats; i++) begin
         next_word(w);
         if (check_data) check_word({name, " data"}, exp_words[i], w);
      end
      next_word(w);
      check_word({name, " address"}, last_addr, w);
      next_word(w);
      check_word({name, " result"}, result, w);
      exp_words.delete();
   endtask

   // data_words must hold count words, commit says whether the slave should keep them
   task automatic write_burst(input string name, input int id, input logic cont,
                              input wbm_pkg::word_t addr, input int step, input int count,
                              input logic commit, input wbm_pkg::word_t result);
      wbm_pkg::word_t cmd_w;
      int             i;
      cmd_w = make_cmd(wbm_pkg::OP_WRITE, count, id, cont, step);
      if (commit) begin
         for (i = 0; i < count; i++) shadow[mem_index(addr, i, step)] = data_words[i];
      end
      send_command(cmd_w, addr, 32'h0);
      exp_words.push_back(wbm_pkg::WRITE_PAD);
      check_response(name, cmd_w, addr, 1'b1, result);
   endtask

   task automatic read_burst(input string name, input int id, input logic cont,
                             input wbm_pkg::word_t addr, input int step, input int count,
                             input logic check_data, input wbm_pkg::word_t result);
      wbm_pkg::word_t cmd_w;
      int             i;
      cmd_w = make_cmd(wbm_pkg::OP_READ, count, id, cont, step);
      for (i = 0; i < count; i++) exp_words.push_back(shadow[mem_index(addr, i, step)]);
      data_words.push_back(32'h0);     // a read still carries one dummy data word
      send_command(cmd_w, addr, 32'h0);
      check_response(name, cmd_w, addr, check_data, result);
   endtask

   task automatic end_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("test %s: passed", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - errs_before);
      end
   endtask

   // ----------------------------------------------------------------------
   initial begin : stimulus
      int             base;
      int             i;
      wbm_pkg::word_t cmd_w;
      wbm_pkg::word_t new_dat;
      wbm_pkg::word_t mask;
      wbm_pkg::word_t merged;

      while (wb_rst) @(posedge wb_clk);

      base = errors;                   // single write, then read back
      data_words.push_back($random(seed));
      write_burst("single_write_read", 1, 1'b0, 32'h5, 1, 1, 1'b1, 32'd0);
      read_burst("single_write_read", 2, 1'b0, 32'h5, 1, 1, 1'b1, 32'd0);
      end_test("single_write_read", base);

      base = errors;
      for (i = 0; i < 4; i++) data_words.push_back($random(seed));
      write_burst("burst_write_read", 3, 1'b0, 32'h10, 1, 4, 1'b1, 32'd0);
      read_burst("burst_write_read", 4, 1'b0, 32'h10, 1, 4, 1'b1, 32'd0);
      end_test("burst_write_read", base);

      base = errors;                   // masked bits take the new data
      mask    = 32'h00ff_f00f;
      new_dat = $random(seed);
      merged  = (shadow[5] & ~mask) | (new_dat & mask);
      cmd_w   = make_cmd(wbm_pkg::OP_RMW, 1, 5, 1'b0, 1);
      data_words.push_back(new_dat);
      send_command(cmd_w, 32'h5, mask);
      exp_words.push_back(shadow[5]);  // old data comes back
      check_response("read_modify_write", cmd_w, 32'h5, 1'b1, 32'd0);
      shadow[5] = merged;
      read_burst("read_modify_write", 6, 1'b0, 32'h5, 1, 1, 1'b1, 32'd0);
      end_test("read_modify_write", base);

      base = errors;                   // the slave never answers this window
      read_burst("bus_timeout", 7, 1'b0, 32'h8000_0003, 1, 1, 1'b0, 32'd1);
      end_test("bus_timeout", base);

      base = errors;
      skip_window = 1'b1;
      data_words.push_back($random(seed));
      write_burst("skip_after_timeout", 8, 1'b1, 32'h11, 1, 1, 1'b0, 32'd1);
      skip_window = 1'b0;
      read_burst("skip_after_timeout", 9, 1'b0, 32'h11, 1, 1, 1'b1, 32'd0);
      end_test("skip_after_timeout", base);

      base = errors;                   // long bursts against scarce out credits
      credit_thresh = 1;
      for (i = 0; i < 20; i++) data_words.push_back($random(seed));
      write_burst("flow_control", 10, 1'b0, 32'h18, 2, 20, 1'b1, 32'd0);
      read_burst("flow_control", 11, 1'b0, 32'h18, 2, 20, 1'b1, 32'd0);
      credit_thresh = 6;
      end_test("flow_control", base);

      assert (rx_words.size() == 0)
         else begin
            $display("response words arrived that no command asked for");
            errors++;
         end

      $display("summary: 6 tests, %0d failing, %0d errors", tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

/* dv/wb_slave_model.sv */
`timescale 1ns/1ps
// memory-backed wishbone slave for the testbench
// acks one clock after a strobe and never acks addresses with bit 31 set

module wb_slave_model (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  wbm_pkg::wb_m2s_t m2s_i,
   output wbm_pkg::wb_s2m_t s2m_o
);

   wbm_pkg::word_t mem [64];          // word addressed, low six address bits
   logic           ack_q = 1'b0;
   wbm_pkg::word_t rd_q  = '0;
   logic           hit;               // a strobe this slave answers
   logic [5:0]     idx;

   assign idx = m2s_i.adr[5:0];
   // bit 31 marks the window that lets the master run into its timeout
   assign hit = m2s_i.cyc && m2s_i.stb && !ack_q && !m2s_i.adr[31];

   // every location starts with a value that depends on its address
   initial begin : fill
      int i;
      for (i = 0; i < 64; i++) begin
         mem[i] = 32'hc0de_0000 ^ (wbm_pkg::word_t'(i) * 32'h0001_0203);
      end
   end

   always @(posedge wb_clk) begin
      if (wb_rst) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= hit;                  // single-clock ack, drops when the master ends the cycle
         if (hit) begin
            if (m2s_i.we) mem[idx] <= m2s_i.dat;
            rd_q <= mem[idx];
         end
      end
   end

   // read data is only driven together with ack
   assign s2m_o = '{ack: ack_q, dat: (ack_q ? rd_q : 32'h0)};

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps
// clock and reset source for the testbench

module tb_clk_gen #(
   parameter int HALF_PERIOD  = 10,   // ns, gives the 20 ns wb_clk
   parameter int RESET_CYCLES = 8
) (
   output logic wb_clk,
   output logic wb_rst
);

   initial begin
      wb_clk = 1'b0;
      forever #(HALF_PERIOD) wb_clk = ~wb_clk;
   end

   // reset drops on a rising edge like the rest of the stimulus
   initial begin
      wb_rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge wb_clk);
      wb_rst <= 1'b0;
   end

endmodule

/* rtl/wbm_top.sv */
`timescale 1ns/1ps
// wishbone host master, top level
// input queue, sequencer, cycle engine and output queue on one clock

module wbm_top (
   input  logic             wb_clk,
   input  logic             wb_rst,
   input  logic             in_valid_i,
   input  wbm_pkg::word_t   in_word_i,
   output logic             in_credit_o,
   output logic             out_valid_o,
   output wbm_pkg::word_t   out_word_o,
   input  logic             out_credit_i,
   output wbm_pkg::wb_m2s_t wb_o,
   input  wbm_pkg::wb_s2m_t wb_i
);

   wbm_pkg::word_t    head;         // input queue head
   logic              head_valid;
   logic              pop;
   logic              push;
   wbm_pkg::word_t    push_word;
   logic              tx_ready;
   logic              req_valid;
   wbm_pkg::bus_req_t req;
   logic              rsp_valid;
   wbm_pkg::bus_rsp_t rsp;

   host_rx u_rx (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .in_valid_i (in_valid_i), .in_word_i (in_word_i), .in_credit_o (in_credit_o),
      .head_o (head), .head_valid_o (head_valid), .pop_i (pop)
   );

   wbm_sequencer u_seq (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .head_i (head), .head_valid_i (head_valid), .pop_o (pop),
      .push_o (push), .push_word_o (push_word), .tx_ready_i (tx_ready),
      .req_valid_o (req_valid), .req_o (req), .rsp_valid_i (rsp_valid), .rsp_i (rsp)
   );

   wb_cycle u_cycle (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .req_valid_i (req_valid), .req_i (req), .rsp_valid_o (rsp_valid), .rsp_o (rsp),
      .wb_o (wb_o), .wb_i (wb_i)
   );

   host_tx u_tx (
      .wb_clk (wb_clk), .wb_rst (wb_rst),
      .push_i (push), .word_i (push_word), .ready_o (tx_ready),
      .out_valid_o (out_valid_o), .out_word_o (out_word_o), .out_credit_i (out_credit_i)
   );

endmodule

/* rtl/wbm_sequencer.sv */
`timescale 1ns/1ps
// command sequencer of the host master
// parses host commands, orders the bus cycles and builds the response words

module wbm_sequencer (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  wbm_pkg::word_t      head_i,
   input  logic                head_valid_i,
   output logic                pop_o,
   output logic                push_o,
   output wbm_pkg::word_t      push_word_o,
   input  logic                tx_ready_i,
   output logic                req_valid_o,
   output wbm_pkg::bus_req_t   req_o,
   input  logic                rsp_valid_i,
   input  wbm_pkg::bus_rsp_t   rsp_i
);

   typedef enum logic [3:0] {
      ST_CMD, ST_ADDR, ST_MASK, ST_DATA, ST_BUS,
      ST_ECHO, ST_WDATA, ST_WADDR, ST_RESULT
   } state_t;

   state_t           state;
   wbm_pkg::cmd_t    cmd_q;
   wbm_pkg::cmd_t    head_cmd;      // head word seen as a command
   wbm_pkg::word_t   addr_q;        // address of the current beat, reported at the end
   wbm_pkg::word_t   mask_q;
   wbm_pkg::word_t   data_q;
   wbm_pkg::word_t   rd_data_q;     // read data, or the old data of a read-modify-write
   wbm_pkg::word_t   step_w;
   wbm_pkg::word_t   merged;
   wbm_pkg::count_t  in_cnt;        // data words taken from the input queue
   wbm_pkg::count_t  out_cnt;       // data words pushed into the response
   logic             to_flag;       // sticky timeout, lives until a block starts again
   logic             rmw_wr_q;      // read-modify-write is in its write half
   logic             is_read;
   logic             is_write;
   logic             is_rmw;
   logic             in_last;
   logic             out_last;

   assign head_cmd = wbm_pkg::cmd_t'(head_i);
   assign step_w   = wbm_pkg::word_t'(cmd_q.addr_step);
   assign merged   = (rsp_i.dat & ~mask_q) | (data_q & mask_q);   // masked bits take new data
   assign is_read  = cmd_q.op == wbm_pkg::OP_READ;
   assign is_write = cmd_q.op == wbm_pkg::OP_WRITE;
   assign is_rmw   = cmd_q.op == wbm_pkg::OP_RMW;
   // only a burst write brings more than one data word
   assign in_last  = !is_write || (in_cnt + 1'b1 >= cmd_q.count);
   // only a burst read returns more than one data word
   assign out_last = !is_read || (out_cnt + 1'b1 >= cmd_q.count);

   // ----------------------------------------------------------------------
   // queue strobes follow the state directly
   always_comb begin
      pop_o  = head_valid_i && (state inside {ST_CMD, ST_ADDR, ST_MASK, ST_DATA});
      push_o = tx_ready_i && (state inside {ST_ECHO, ST_WDATA, ST_WADDR, ST_RESULT});
      case (state)
         ST_ECHO:  push_word_o = wbm_pkg::word_t'(cmd_q);
         ST_WDATA: push_word_o = is_write ? wbm_pkg::WRITE_PAD : rd_data_q;
         ST_WADDR: push_word_o = addr_q;
         default:  push_word_o = wbm_pkg::word_t'(to_flag);        // result word, bit 0
      endcase
   end

   // ----------------------------------------------------------------------
   always_ff @(posedge wb_clk) begin
      req_valid_o <= 1'b0;                    // request is a one-clock pulse

      case (state)
         ST_CMD: if (head_valid_i) begin
            cmd_q    <= head_cmd;
            in_cnt   <= '0;
            out_cnt  <= '0;
            rmw_wr_q <= 1'b0;
            if (!head_cmd.cont) to_flag <= 1'b0;   // a new block forgets an old timeout
            state    <= ST_ADDR;
         end
         ST_ADDR: if (head_valid_i) begin
            addr_q <= head_i;
            state  <= ST_MASK;
         end
         ST_MASK: if (head_valid_i) begin
            mask_q <= head_i;                 // dummy word unless read-modify-write
            state  <= ST_DATA;
         end
         ST_DATA: if (head_valid_i) begin
            data_q <= head_i;
            in_cnt <= in_cnt + 1'b1;
            if (to_flag || !(is_read || is_write || is_rmw)) begin
               // no bus cycle, the word is dropped but the beat still counts
               if (in_last) state <= ST_ECHO;
               else         addr_q <= addr_q + step_w;
            end else begin
               req_valid_o <= 1'b1;           // reads and the first half of rmw have we low
               req_o       <= '{we: is_write, adr: addr_q, dat: head_i};
               state       <= ST_BUS;
            end
         end
         ST_BUS: if (rsp_valid_i) begin
            if (rsp_i.timed_out) to_flag <= 1'b1;
            if (is_write) begin
               if (in_cnt >= cmd_q.count) begin
                  state <= ST_ECHO;
               end else begin
                  addr_q <= addr_q + step_w;
                  state  <= ST_DATA;          // fetch the next burst word
               end
            end else if (is_rmw && !rmw_wr_q) begin
               rd_data_q <= rsp_i.dat;
               if (rsp_i.timed_out) begin
                  state <= ST_ECHO;           // nothing to merge with
               end else begin
                  rmw_wr_q    <= 1'b1;
                  req_valid_o <= 1'b1;
                  req_o       <= '{we: 1'b1, adr: addr_q, dat: merged};
               end
            end else if (is_rmw) begin
               state <= ST_ECHO;
            end else begin
               rd_data_q <= rsp_i.dat;
               state     <= (out_cnt == '0) ? ST_ECHO : ST_WDATA;   // echo goes first
            end
         end
         ST_ECHO: if (tx_ready_i) state <= ST_WDATA;
         ST_WDATA: if (tx_ready_i) begin
            out_cnt <= out_cnt + 1'b1;
            if (out_last) begin
               state <= ST_WADDR;
            end else begin
               addr_q <= addr_q + step_w;
               // after a timeout the burst read still returns count words
               if (!to_flag) begin
                  req_valid_o <= 1'b1;
                  req_o       <= '{we: 1'b0, adr: addr_q + step_w, dat: data_q};
                  state       <= ST_BUS;
               end
            end
         end
         ST_WADDR:  if (tx_ready_i) state <= ST_RESULT;
         ST_RESULT: if (tx_ready_i) state <= ST_CMD;
         default:   state <= ST_CMD;
      endcase

      // control state only, the captured words keep whatever they hold
      if (wb_rst) begin
         state       <= ST_CMD;
         to_flag     <= 1'b0;
         rmw_wr_q    <= 1'b0;
         in_cnt      <= '0;
         out_cnt     <= '0;
         req_valid_o <= 1'b0;
      end
   end

endmodule

/* rtl/wb_cycle.sv */
`timescale 1ns/1ps
// wishbone cycle engine
// runs one classic cycle per request, ends it on ack or after the timeout

module wb_cycle (
   input  logic                wb_clk,
   input  logic                wb_rst,
   input  logic                req_valid_i,
   input  wbm_pkg::bus_req_t   req_i,
   output logic                rsp_valid_o,
   output wbm_pkg::bus_rsp_t   rsp_o,
   output wbm_pkg::wb_m2s_t    wb_o,
   input  wbm_pkg::wb_s2m_t    wb_i
);

   logic            cyc_q;
   logic            stb_q;
   logic            we_q;
   wbm_pkg::word_t  adr_q;
   wbm_pkg::word_t  dat_q;
   wbm_pkg::timer_t timer_q;    // clocks spent in the current cycle
   logic            start;
   logic            done;

   assign start = req_valid_i && !cyc_q;
   // ack wins over a timeout in the same clock
   assign done  = cyc_q && (wb_i.ack || timer_q == wbm_pkg::TIMER_LAST);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cyc_q       <= 1'b0;
         stb_q       <= 1'b0;
         timer_q     <= '0;
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= done;                 // one pulse per finished cycle
         if (done) begin
            cyc_q <= 1'b0;
            stb_q <= 1'b0;
         end else if (start) begin
            cyc_q   <= 1'b1;
            stb_q   <= 1'b1;
            timer_q <= '0;
         end else if (cyc_q) begin
            timer_q <= timer_q + 1'b1;
         end
      end
   end

   always_ff @(posedge wb_clk) begin
      if (start) begin
         we_q  <= req_i.we;                   // request held for the whole cycle
         adr_q <= req_i.adr;
         dat_q <= req_i.dat;
      end
      if (done) begin
         rsp_o.dat       <= wb_i.dat;
         rsp_o.timed_out <= !wb_i.ack;
      end
   end

   assign wb_o = '{cyc: cyc_q, stb: stb_q, we: we_q, adr: adr_q, dat: dat_q};

   assert property (@(posedge wb_clk) disable iff (wb_rst) $rose(wb_o.stb) |-> wb_o.cyc)
      else $error("stb raised without cyc");
   // the sequencer keeps at most one cycle outstanding
   assert property (@(posedge wb_clk) disable iff (wb_rst) req_valid_i |-> !cyc_q)
      else $error("bus request while a cycle is running");

endmodule

/* rtl/host_tx.sv */
`timescale 1ns/1ps
// host output queue
// sends one word per cycle while the host has granted credits

module host_tx (
   input  logic           wb_clk,
   input  logic           wb_rst,
   input  logic           push_i,
   input  wbm_pkg::word_t word_i,
   output logic           ready_o,
   output logic           out_valid_o,
   output wbm_pkg::word_t out_word_o,
   input  logic           out_credit_i
);

   wbm_pkg::word_t   q_head;
   logic             q_valid;
   logic             q_full;
   logic             send;       // a word leaves the queue this cycle
   wbm_pkg::credit_t credits;    // words the host can still take

   word_fifo #(
      .payload_t (wbm_pkg::word_t),
      .DEPTH     (wbm_pkg::FIFO_DEPTH)
   ) u_fifo (
      .wb_clk  (wb_clk),
      .wb_rst  (wb_rst),
      .push_i  (push_i),
      .data_i  (word_i),
      .pop_i   (send),
      .data_o  (q_head),
      .valid_o (q_valid),
      .full_o  (q_full)
   );

   assign ready_o = !q_full;                  // the sequencer pushes only while this is high
   assign send    = q_valid && (credits != '0);

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         credits     <= wbm_pkg::CREDIT_INIT;    // host buffer starts empty
         out_valid_o <= 1'b0;
      end else begin
         out_valid_o <= send;
         case ({out_credit_i, send})
            2'b10:   credits <= credits + 1'b1;
            2'b01:   credits <= credits - 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (send) out_word_o <= q_head;         // registered output word
   end

   // the host can never return more credits than it was given
   assert property (@(posedge wb_clk) disable iff (wb_rst) credits <= wbm_pkg::CREDIT_INIT)
      else $error("output credits above the host buffer size");

endmodule

/* rtl/host_rx.sv */
`timescale 1ns/1ps
// host input queue
// buffers incoming host words and hands one credit back per word consumed

module host_rx (
   input  logic           wb_clk,
   input  logic           wb_rst,
   input  logic           in_valid_i,
   input  wbm_pkg::word_t in_word_i,
   output logic           in_credit_o,
   output wbm_pkg::word_t head_o,
   output logic           head_valid_o,
   input  logic           pop_i
);

   logic rx_full;   // only watched, credits keep the host from filling it

   word_fifo #(
      .payload_t (wbm_pkg::word_t),
      .DEPTH     (wbm_pkg::FIFO_DEPTH)
   ) u_fifo (
      .wb_clk  (wb_clk),
      .wb_rst  (wb_rst),
      .push_i  (in_valid_i),
      .data_i  (in_word_i),
      .pop_i   (pop_i),
      .data_o  (head_o),
      .valid_o (head_valid_o),
      .full_o  (rx_full)
   );

   // a freed slot goes back to the host one cycle after the pop
   always_ff @(posedge wb_clk) begin
      if (wb_rst) in_credit_o <= 1'b0;
      else        in_credit_o <= pop_i && head_valid_o;
   end

   // a word arriving while full means the host sent without a credit
   assert property (@(posedge wb_clk) disable iff (wb_rst) in_valid_i |-> !rx_full)
      else $error("host sent a word without credit");

endmodule

/* rtl/word_fifo.sv */
`timescale 1ns/1ps
// synchronous first-word-fall-through FIFO with a type parameter payload
// the head entry shows on data_o while valid_o is high

module word_fifo #(
   parameter type payload_t = logic,
   parameter int  DEPTH     = 16
) (
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t data_o,
   output logic     valid_o,
   output logic     full_o
);

   payload_t                 mem [DEPTH];   // circular storage
   logic [$clog2(DEPTH)-1:0] wr_ptr;        // pointers wrap on their own, DEPTH is a power of two
   logic [$clog2(DEPTH)-1:0] rd_ptr;
   logic [$clog2(DEPTH):0]   count;         // one bit wider so that DEPTH fits
   logic                     do_push;
   logic                     do_pop;

   assign do_push = push_i && !full_o;      // a push into a full queue is lost
   assign do_pop  = pop_i && valid_o;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;          // both or neither leave the level alone
         endcase
      end
   end

   always_ff @(posedge wb_clk) begin
      if (do_push) mem[wr_ptr] <= data_i;
   end

   assign data_o  = mem[rd_ptr];            // no read delay on the head
   assign valid_o = count != '0;
   assign full_o  = count == DEPTH[$clog2(DEPTH):0];

   // the writer and the reader both have to respect the levels
   assert property (@(posedge wb_clk) disable iff (wb_rst) !(push_i && full_o))
      else $error("push into a full FIFO");
   assert property (@(posedge wb_clk) disable iff (wb_rst) !(pop_i && !valid_o))
      else $error("pop from an empty FIFO");

endmodule

/* rtl/wbm_pkg.sv */
// shared definitions for the wishbone host master
// word sizes, queue depths, the command word layout and the bus structs

package wbm_pkg;

   localparam int WORD_W         = 32;                       // host and bus word width
   localparam int FIFO_DEPTH     = 16;                       // both queues, also the starting credits
   localparam int CREDIT_W       = $clog2(FIFO_DEPTH) + 1;   // must hold FIFO_DEPTH itself
   localparam int TIMEOUT_CYCLES = 100;                      // clocks a cycle waits for ack
   localparam int TIMER_W        = $clog2(TIMEOUT_CYCLES);

   typedef logic [WORD_W-1:0]   word_t;
   typedef logic [CREDIT_W-1:0] credit_t;
   typedef logic [TIMER_W-1:0]  timer_t;
   typedef logic [12:0]         count_t;                     // width of the count field
   typedef logic [1:0]          op_t;

   localparam credit_t CREDIT_INIT = credit_t'(FIFO_DEPTH);
   localparam timer_t  TIMER_LAST  = timer_t'(TIMEOUT_CYCLES - 1);
   localparam word_t   WRITE_PAD   = 32'hdeadbeef;           // data word reported for writes

   localparam op_t OP_READ  = 2'd0;
   localparam op_t OP_WRITE = 2'd1;
   localparam op_t OP_RMW   = 2'd2;

   // command word, first field sits in the top bits
   typedef struct packed {
      logic [7:0] addr_step;   // address increment between burst beats
      logic       cont;        // 0 starts a new block and clears a pending timeout
      logic [7:0] id;
      count_t     count;       // number of beats
      op_t        op;
   } cmd_t;

   // ----------------------------------------------------------------------
   // sequencer to cycle engine and back
   typedef struct packed {
      logic  we;
      word_t adr;
      word_t dat;
   } bus_req_t;

   typedef struct packed {
      word_t dat;
      logic  timed_out;
   } bus_rsp_t;

   // ----------------------------------------------------------------------
   // wishbone signals as seen from the master
   typedef struct packed {
      logic  cyc;
      logic  stb;
      logic  we;
      word_t adr;
      word_t dat;
   } wb_m2s_t;

   typedef struct packed {
      logic  ack;
      word_t dat;
   } wb_s2m_t;

endpackage
